//--- hdl/hisPkg.sv
`default_nettype none

package hisPkg;

    // sample code width, 0..1023
    localparam int sampleWidth = 10;

    // histogram geometry
    localparam int numBins     = 16;
    localparam int binIdxWidth = 4;

    // bins split over identical banks
    localparam int numBanks     = 4;
    localparam int binsPerBank  = 4;
    // low index bits pick the counter inside a bank
    localparam int slotWidth    = 2;
    // high index bits pick the bank
    localparam int bankSelWidth = binIdxWidth - slotWidth;

    // saturating bin counters
    localparam int countWidth = 8;
    localparam logic [countWidth-1:0] countMax = '1;

    // coarse bin is 64 codes wide
    localparam int coarseShift = 6;
    // fine bin is 4 codes wide
    localparam int fineShift   = 2;

    // fine window covers exactly one coarse bin
    localparam logic [sampleWidth-1:0] windowSpan = sampleWidth'(1 << coarseShift);
    // offset to the middle of a fine bin
    localparam logic [sampleWidth-1:0] fineCentre = sampleWidth'(1 << (fineShift - 1));

    // which histogram is being built
    typedef enum logic {
        coarsePass = 1'b0,
        finePass   = 1'b1
    } passT;

endpackage

`default_nettype wire

//--- hdl/binMapper.sv
`timescale 1ns/1ps
`default_nettype none

module binMapper (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           sampleValid,
    input  logic [hisPkg::sampleWidth-1:0] sampleData,
    input  logic                           acceptEn,
    input  hisPkg::passT                   pass,
    input  logic [hisPkg::sampleWidth-1:0] windowBase,
    output logic                           binStrobe,
    output logic [hisPkg::binIdxWidth-1:0] binIndex
);
    import hisPkg::*;

    logic                   accepted;
    logic [sampleWidth-1:0] offset;
    logic                   inWindow;
    logic [sampleWidth-1:0] offsetQ;

    // handshake seen at the top, ready is acceptEn
    assign accepted = sampleValid && acceptEn;

    // codes below the base wrap to a large offset and fall out
    assign offset   = sampleData - windowBase;
    assign inWindow = offset < windowSpan;

    // strobe register, one cycle behind the accepted sample
    always_ff @(posedge clk) begin
        if (!rstN) begin
            binStrobe <= 1'b0;
        end else begin
            // coarse pass covers the whole range
            binStrobe <= accepted && ((pass == coarsePass) || inWindow);
        end
    end

    // index and offset only move on accepted samples
    always_ff @(posedge clk) begin
        if (accepted) begin
            offsetQ <= offset;
            if (pass == coarsePass) begin
                // top code bits give the coarse bin
                binIndex <= binIdxWidth'(sampleData >> coarseShift);
            end else begin
                // offset inside the 64-code window, 4 codes per bin
                binIndex <= binIdxWidth'(offset >> fineShift);
            end
        end
    end

    // out-of-window fine samples never reach the banks
    fineInWindow: assert property (
        @(posedge clk) disable iff (!rstN)
        (binStrobe && (pass == finePass)) |-> (offsetQ < windowSpan)
    ) else $error("binMapper: fine strobe with offset %0d", offsetQ);

endmodule

`default_nettype wire

//--- hdl/binBank.sv
`timescale 1ns/1ps
`default_nettype none

module binBank #(
    parameter int bankId = 0
) (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           clearBins,
    input  logic                           binStrobe,
    input  logic [hisPkg::binIdxWidth-1:0] binIndex,
    input  logic                           scanReq,
    output logic [hisPkg::countWidth-1:0]  localMax,
    output logic [hisPkg::binIdxWidth-1:0] localIdx,
    output logic                           localDone
);
    import hisPkg::*;

    logic [countWidth-1:0] binCount [binsPerBank];
    logic                  bankHit;
    logic [slotWidth-1:0]  slot;
    logic [countWidth-1:0] bestCount;
    logic [slotWidth-1:0]  bestSlot;

    // broadcast strobe, keep only indices owned by this bank
    assign bankHit = binStrobe &&
                     (binIndex[binIdxWidth-1 -: bankSelWidth] == bankSelWidth'(bankId));
    assign slot    = binIndex[slotWidth-1:0];

    // counters, held at max once full
    always_ff @(posedge clk) begin
        if (!rstN || clearBins) begin
            for (int i = 0; i < binsPerBank; i++) begin
                binCount[i] <= '0;
            end
        end else if (bankHit && (binCount[slot] != countMax)) begin
            binCount[slot] <= binCount[slot] + 1'b1;
        end
    end

    // argmax over the four counters
    always_comb begin
        bestCount = binCount[0];
        bestSlot  = '0;
        for (int i = 1; i < binsPerBank; i++) begin
            // strict compare so a tie keeps the lower slot
            if (binCount[i] > bestCount) begin
                bestCount = binCount[i];
                bestSlot  = slotWidth'(i);
            end
        end
    end

    // done pulse follows scanReq by one cycle
    always_ff @(posedge clk) begin
        if (!rstN) begin
            localDone <= 1'b0;
        end else begin
            localDone <= scanReq;
        end
    end

    // snapshot of the bank maximum, index made global
    always_ff @(posedge clk) begin
        if (scanReq) begin
            localMax <= bestCount;
            localIdx <= {bankSelWidth'(bankId), bestSlot};
        end
    end

    // a full counter must stay full until cleared
    for (genvar g = 0; g < binsPerBank; g++) begin : genWrapCheck
        noWrap: assert property (
            @(posedge clk) disable iff (!rstN)
            ((binCount[g] == countMax) && !clearBins) |=> (binCount[g] != '0)
        ) else $error("binBank %0d: counter %0d wrapped", bankId, g);
    end

endmodule

`default_nettype wire

//--- hdl/peakReducer.sv
`timescale 1ns/1ps
`default_nettype none

module peakReducer (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic [hisPkg::countWidth-1:0]  localMax [hisPkg::numBanks],
    input  logic [hisPkg::binIdxWidth-1:0] localIdx [hisPkg::numBanks],
    input  logic [hisPkg::numBanks-1:0]    localDone,
    output logic                           peakDone,
    output logic [hisPkg::binIdxWidth-1:0] peakIdx,
    output logic [hisPkg::countWidth-1:0]  peakCnt
);
    import hisPkg::*;

    logic                   allDone;
    logic [countWidth-1:0]  bestCnt;
    logic [binIdxWidth-1:0] bestIdx;

    // banks scan in lockstep
    assign allDone = &localDone;

    // bank order is index order, strict compare keeps the lower bin
    always_comb begin
        bestCnt = localMax[0];
        bestIdx = localIdx[0];
        for (int b = 1; b < numBanks; b++) begin
            if (localMax[b] > bestCnt) begin
                bestCnt = localMax[b];
                bestIdx = localIdx[b];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            peakDone <= 1'b0;
        end else begin
            peakDone <= allDone;
        end
    end

    // winner held until the next scan
    always_ff @(posedge clk) begin
        if (allDone) begin
            peakIdx <= bestIdx;
            peakCnt <= bestCnt;
        end
    end

    // one scanReq reaches every bank
    banksInStep: assert property (
        @(posedge clk) disable iff (!rstN)
        (localDone == '0) || (&localDone)
    ) else $error("peakReducer: banks out of step %b", localDone);

endmodule

`default_nettype wire

//--- hdl/histSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module histSequencer (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           start,
    input  logic                           sampleValid,
    input  logic                           sampleLast,
    input  logic                           peakDone,
    input  logic [hisPkg::binIdxWidth-1:0] peakIdx,
    input  logic [hisPkg::countWidth-1:0]  peakCnt,
    input  logic                           resultReady,
    output logic                           acceptEn,
    output hisPkg::passT                   pass,
    output logic [hisPkg::sampleWidth-1:0] windowBase,
    output logic                           clearBins,
    output logic                           scanReq,
    output logic                           busy,
    output logic                           resultValid,
    output logic [hisPkg::binIdxWidth-1:0] coarseBin,
    output logic [hisPkg::binIdxWidth-1:0] fineBin,
    output logic [hisPkg::sampleWidth-1:0] peakCode,
    output logic [hisPkg::countWidth-1:0]  peakCount
);
    import hisPkg::*;

    typedef enum logic [2:0] {
        stIdle,
        stCoarseCollect,
        stCoarseDrain,
        stCoarseScan,
        stFineCollect,
        stFineDrain,
        stFineScan,
        stResult
    } stateT;

    stateT state;
    logic  lastTaken;

    // acceptEn drops on the edge that takes the last sample
    assign acceptEn  = (state == stCoarseCollect) || (state == stFineCollect);
    assign lastTaken = acceptEn && sampleValid && sampleLast;

    assign pass = ((state == stFineCollect) || (state == stFineDrain) ||
                   (state == stFineScan)) ? finePass : coarsePass;

    assign busy        = (state != stIdle);
    assign resultValid = (state == stResult);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state     <= stIdle;
            clearBins <= 1'b0;
            scanReq   <= 1'b0;
        end else begin
            // both strobes are single-cycle
            clearBins <= 1'b0;
            scanReq   <= 1'b0;
            case (state)
                stIdle: begin
                    if (start) begin
                        state     <= stCoarseCollect;
                        clearBins <= 1'b1;
                    end
                end
                stCoarseCollect: begin
                    if (lastTaken) begin
                        state <= stCoarseDrain;
                    end
                end
                // last bin lands in the banks here
                stCoarseDrain: begin
                    state   <= stCoarseScan;
                    scanReq <= 1'b1;
                end
                stCoarseScan: begin
                    if (peakDone) begin
                        // fine pass starts on empty bins
                        state     <= stFineCollect;
                        clearBins <= 1'b1;
                    end
                end
                stFineCollect: begin
                    if (lastTaken) begin
                        state <= stFineDrain;
                    end
                end
                stFineDrain: begin
                    state   <= stFineScan;
                    scanReq <= 1'b1;
                end
                stFineScan: begin
                    if (peakDone) begin
                        state <= stResult;
                    end
                end
                // start is ignored until the result is taken
                stResult: begin
                    if (resultReady) begin
                        state <= stIdle;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // result fields, written once per pass
    always_ff @(posedge clk) begin
        if ((state == stCoarseScan) && peakDone) begin
            coarseBin  <= peakIdx;
            // window starts at the coarse bin's first code
            windowBase <= sampleWidth'(peakIdx) << coarseShift;
        end
        if ((state == stFineScan) && peakDone) begin
            fineBin   <= peakIdx;
            peakCode  <= windowBase + (sampleWidth'(peakIdx) << fineShift) + fineCentre;
            peakCount <= peakCnt;
        end
    end

    // result held steady under back-pressure
    resultHeld: assert property (
        @(posedge clk) disable iff (!rstN)
        (resultValid && !resultReady) |=>
            (resultValid && $stable(peakCode) && $stable(peakCount) &&
             $stable(coarseBin) && $stable(fineBin))
    ) else $error("histSequencer: result dropped or changed before handshake");

endmodule

`default_nettype wire

//--- hdl/hisBuilderTop.sv
`timescale 1ns/1ps
`default_nettype none

module hisBuilderTop (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           start,
    input  logic                           sampleValid,
    input  logic [hisPkg::sampleWidth-1:0] sampleData,
    input  logic                           sampleLast,
    input  logic                           resultReady,
    output logic                           sampleReady,
    output logic                           busy,
    output logic                           resultValid,
    output logic [hisPkg::binIdxWidth-1:0] coarseBin,
    output logic [hisPkg::binIdxWidth-1:0] fineBin,
    output logic [hisPkg::sampleWidth-1:0] peakCode,
    output logic [hisPkg::countWidth-1:0]  peakCount
);
    import hisPkg::*;

    // sequencer to mapper
    passT                   pass;
    logic [sampleWidth-1:0] windowBase;

    // mapper broadcast to every bank
    logic                   binStrobe;
    logic [binIdxWidth-1:0] binIndex;

    // sequencer strobes to banks
    logic                   clearBins;
    logic                   scanReq;

    // banks to reducer
    logic [countWidth-1:0]  localMax [numBanks];
    logic [binIdxWidth-1:0] localIdx [numBanks];
    logic [numBanks-1:0]    localDone;

    // reducer to sequencer
    logic                   peakDone;
    logic [binIdxWidth-1:0] peakIdx;
    logic [countWidth-1:0]  peakCnt;

    // sampleReady is the sequencer's acceptEn
    binMapper binMapperU0 (
        .clk        (clk),
        .rstN       (rstN),
        .sampleValid(sampleValid),
        .sampleData (sampleData),
        .acceptEn   (sampleReady),
        .pass       (pass),
        .windowBase (windowBase),
        .binStrobe  (binStrobe),
        .binIndex   (binIndex)
    );

    for (genvar b = 0; b < numBanks; b++) begin : genBank
        binBank #(
            .bankId(b)
        ) binBankU (
            .clk      (clk),
            .rstN     (rstN),
            .clearBins(clearBins),
            .binStrobe(binStrobe),
            .binIndex (binIndex),
            .scanReq  (scanReq),
            .localMax (localMax[b]),
            .localIdx (localIdx[b]),
            .localDone(localDone[b])
        );
    end

    peakReducer peakReducerU0 (
        .clk      (clk),
        .rstN     (rstN),
        .localMax (localMax),
        .localIdx (localIdx),
        .localDone(localDone),
        .peakDone (peakDone),
        .peakIdx  (peakIdx),
        .peakCnt  (peakCnt)
    );

    histSequencer histSequencerU0 (
        .clk        (clk),
        .rstN       (rstN),
        .start      (start),
        .sampleValid(sampleValid),
        .sampleLast (sampleLast),
        .peakDone   (peakDone),
        .peakIdx    (peakIdx),
        .peakCnt    (peakCnt),
        .resultReady(resultReady),
        .acceptEn   (sampleReady),
        .pass       (pass),
        .windowBase (windowBase),
        .clearBins  (clearBins),
        .scanReq    (scanReq),
        .busy       (busy),
        .resultValid(resultValid),
        .coarseBin  (coarseBin),
        .fineBin    (fineBin),
        .peakCode   (peakCode),
        .peakCount  (peakCount)
    );

endmodule

`default_nettype wire

//--- verif/hisBuilderTb.sv
`timescale 1ns/1ps
`default_nettype none

module hisBuilderTb;
    import hisPkg::*;

    // both passes counted, per test in run order
    localparam int drivenSamples = 16 + 80 + 120 + 640 + 96 + 960;
    localparam int numTests      = 6;

    logic                   clk;
    logic                   rstN;
    logic                   start;
    logic                   sampleValid;
    logic [sampleWidth-1:0] sampleData;
    logic                   sampleLast;
    logic                   resultReady;
    logic                   sampleReady;
    logic                   busy;
    logic                   resultValid;
    logic [binIdxWidth-1:0] coarseBin;
    logic [binIdxWidth-1:0] fineBin;
    logic [sampleWidth-1:0] peakCode;
    logic [countWidth-1:0]  peakCount;

    // coarse list also feeds the model's fine pass
    logic [sampleWidth-1:0] coarseSet[$];
    logic [sampleWidth-1:0] fineSet[$];
    int expCoarse;
    int expFine;
    int expCode;
    int expCount;
    int errCount;
    int testErrStart;
    int testsFailed;

    hisBuilderTop u_hisBuilderTop (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // cycle budget from the sample count of all tests
    initial begin
        repeat (drivenSamples * 20 + numTests * 200) @(posedge clk);
        $display("timeout: the tests did not finish within the cycle budget");
        $display("=== FAIL ===");
        $finish;
    end

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            errCount++;
            $display("error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    // lowest index wins a tie
    function automatic int peakBin(input int hist[16]);
        int best;
        best = 0;
        for (int b = 1; b < 16; b++) begin
            if (hist[b] > hist[best]) begin
                best = b;
            end
        end
        return best;
    endfunction

    // reference histograms, 64-code coarse bins, 4-code fine bins, capped at 255
    task automatic computeExpected();
        int coarseHist[16];
        int fineHist[16];
        int off;
        foreach (coarseHist[b]) begin
            coarseHist[b] = 0;
            fineHist[b]   = 0;
        end
        foreach (coarseSet[i]) begin
            if (coarseHist[int'(coarseSet[i]) / 64] < 255) begin
                coarseHist[int'(coarseSet[i]) / 64]++;
            end
        end
        expCoarse = peakBin(coarseHist);
        foreach (coarseSet[i]) begin
            off = int'(coarseSet[i]) - expCoarse * 64;
            // only codes inside the window count
            if (off >= 0 && off < 64 && fineHist[off / 4] < 255) begin
                fineHist[off / 4]++;
            end
        end
        expFine  = peakBin(fineHist);
        expCount = fineHist[expFine];
        expCode  = expCoarse * 64 + expFine * 4 + 2;
    endtask

    // holds the sample until the handshake edge
    task automatic sendSample(input logic [sampleWidth-1:0] code, input logic last);
        sampleValid = 1'b1;
        sampleData  = code;
        sampleLast  = last;
        while (!sampleReady) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        sampleValid = 1'b0;
        sampleLast  = 1'b0;
    endtask

    // start, both passes, wait on resultValid, compare
    task automatic runMeasurement();
        computeExpected();
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        checkVal("busy", 32'(busy), 1);
        checkVal("sampleReady", 32'(sampleReady), 1);
        foreach (coarseSet[i]) begin
            sendSample(coarseSet[i], i == coarseSet.size() - 1);
        end
        foreach (fineSet[i]) begin
            sendSample(fineSet[i], i == fineSet.size() - 1);
        end
        while (!resultValid) begin
            @(posedge clk);
            #1;
        end
        checkVal("coarseBin", 32'(coarseBin), expCoarse);
        checkVal("fineBin", 32'(fineBin), expFine);
        checkVal("peakCode", 32'(peakCode), expCode);
        checkVal("peakCount", 32'(peakCount), expCount);
    endtask

    task automatic takeResult();
        resultReady = 1'b1;
        @(posedge clk);
        #1;
        resultReady = 1'b0;
        checkVal("busy", 32'(busy), 0);
    endtask

    task automatic checkIdle();
        checkVal("sampleReady", 32'(sampleReady), 0);
        checkVal("resultValid", 32'(resultValid), 0);
        checkVal("busy", 32'(busy), 0);
    endtask

    // spread of 21 codes around the centre
    task automatic fillCluster(input int centre, input int n);
        coarseSet.delete();
        for (int i = 0; i < n; i++) begin
            coarseSet.push_back(10'(centre - 10 + (i * 8) % 21));
        end
        fineSet = coarseSet;
    endtask

    task automatic endTest(input string name);
        if (errCount == testErrStart) begin
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: failed with %0d errors", name, errCount - testErrStart);
        end
        testErrStart = errCount;
    endtask

    task automatic testReset();
        rstN = 1'b0;
        repeat (4) begin
            @(posedge clk);
            #1;
            checkIdle();
        end
        rstN = 1'b1;
        @(posedge clk);
        #1;
        checkIdle();
        fillCluster(700, 8);
        runMeasurement();
        takeResult();
        endTest("reset state");
    endtask

    task automatic testCluster();
        fillCluster(300, 40);
        runMeasurement();
        checkVal("coarseBin", 32'(coarseBin), 4);
        takeResult();
        endTest("single cluster");
    endtask

    // extra codes only in the driven fine pass
    task automatic testWindow();
        fillCluster(300, 40);
        // enough copies to take the fine peak if they were counted
        repeat (10) begin
            fineSet.push_front(10'd0);
            // just below the 256..319 window
            fineSet.push_front(10'd255);
            // just above the window
            fineSet.push_back(10'd320);
            fineSet.push_back(10'd1023);
        end
        runMeasurement();
        takeResult();
        endTest("fine window filtering");
    endtask

    task automatic testSaturation();
        coarseSet.delete();
        repeat (300) coarseSet.push_back(10'd517);
        fineSet = coarseSet;
        runMeasurement();
        checkVal("peakCount", 32'(peakCount), 255);
        takeResult();
        // bin 9 arrives first, bin 3 must still win
        coarseSet.delete();
        repeat (10) coarseSet.push_back(10'd600);
        repeat (10) coarseSet.push_back(10'd200);
        fineSet = coarseSet;
        runMeasurement();
        checkVal("coarseBin", 32'(coarseBin), 3);
        takeResult();
        endTest("saturation and tie break");
    endtask

    task automatic testBackPressure();
        fillCluster(450, 24);
        runMeasurement();
        for (int i = 0; i < 10; i++) begin
            // start lands mid-wait
            start = (i == 4);
            @(posedge clk);
            #1;
            checkVal("resultValid", 32'(resultValid), 1);
            checkVal("busy", 32'(busy), 1);
            checkVal("coarseBin", 32'(coarseBin), expCoarse);
            checkVal("fineBin", 32'(fineBin), expFine);
            checkVal("peakCode", 32'(peakCode), expCode);
            checkVal("peakCount", 32'(peakCount), expCount);
        end
        start = 1'b0;
        takeResult();
        checkVal("sampleReady", 32'(sampleReady), 0);
        fillCluster(820, 24);
        runMeasurement();
        takeResult();
        endTest("result back-pressure");
    endtask

    // half the samples near a random centre, half uniform
    task automatic testRandom();
        int centre;
        repeat (4) begin
            coarseSet.delete();
            centre = $urandom % 984;
            repeat (120) begin
                coarseSet.push_back(10'(($urandom % 2 == 1) ? centre + $urandom % 40
                                                            : $urandom % 1024));
            end
            fineSet = coarseSet;
            runMeasurement();
            takeResult();
        end
        endTest("random data sets");
    endtask

    initial begin
        void'($urandom(32'hc83b_a5a1));
        rstN         = 1'b0;
        start        = 1'b0;
        sampleValid  = 1'b0;
        sampleData   = '0;
        sampleLast   = 1'b0;
        resultReady  = 1'b0;
        errCount     = 0;
        testErrStart = 0;
        testsFailed  = 0;
        testReset();
        testCluster();
        testWindow();
        testSaturation();
        testBackPressure();
        testRandom();
        $display("tests %0d, failed %0d, errors %0d", numTests, testsFailed, errCount);
        if (errCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
hdl/hisPkg.sv
hdl/binMapper.sv
hdl/binBank.sv
hdl/peakReducer.sv
hdl/histSequencer.sv
hdl/hisBuilderTop.sv
verif/hisBuilderTb.sv

//--- run.sh
#!/bin/sh
# build and run the histogram peak finder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f sim.f --top-module hisBuilderTb --Mdir obj_dir -o hisBuilderSim

out=$(./obj_dir/hisBuilderSim)
echo "$out"

# exit status follows the search for the pass line
echo "$out" | grep -qx "=== PASS ==="
